// ==== verilog/vex_pkg.sv ====
//----------------------------------------------------------
// Vector execution shared definitions
// Word width, register file size, op codes and the lane ALU
//----------------------------------------------------------
`default_nettype none

package vex_pkg;

    localparam int VEX_XLEN    = 32;
    localparam int VEX_REGS    = 32;
    localparam int VEX_RADDR_W = $clog2(VEX_REGS);

    typedef enum logic [2:0] {
        VEX_ADD  = 3'd0,
        VEX_SUB  = 3'd1,
        VEX_AND  = 3'd2,
        VEX_OR   = 3'd3,
        VEX_XOR  = 3'd4,
        VEX_MINU = 3'd5,
        VEX_MAXU = 3'd6
    } vex_op_e;

    // Control that travels with one micro-op
    typedef struct packed {
        logic                   valid;
        logic [VEX_RADDR_W-1:0] dst;
        vex_op_e                op;
        logic                   is_rdc;
        logic                   head_uop;
        logic                   end_uop;
    } vex_tag_t;

    function automatic logic [VEX_XLEN-1:0] vex_alu(
        input vex_op_e             op,
        input logic [VEX_XLEN-1:0] a,
        input logic [VEX_XLEN-1:0] b
    );
        logic [VEX_XLEN-1:0] res;
        case (op)
            VEX_ADD:  res = a + b;
            VEX_SUB:  res = a - b;
            VEX_AND:  res = a & b;
            VEX_OR:   res = a | b;
            VEX_XOR:  res = a ^ b;
            VEX_MINU: res = (a < b) ? a : b;
            VEX_MAXU: res = (a > b) ? a : b;
            default:  res = '0;
        endcase
        return res;
    endfunction

    // Neutral element of each fold
    function automatic logic [VEX_XLEN-1:0] vex_rdc_identity(input vex_op_e op);
        return (op == VEX_AND || op == VEX_MINU) ? '1 : '0;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/vex_lane.sv ====
//----------------------------------------------------------
// Vector lane
// Element result or reduction operand, registered into EX2
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module vex_lane
    import vex_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_i,
    input  vex_op_e             op_i,
    input  logic                is_rdc_i,
    input  logic                mask_i,
    input  logic [VEX_XLEN-1:0] data_a_i,
    input  logic [VEX_XLEN-1:0] data_b_i,
    output logic [VEX_XLEN-1:0] result_o,
    output logic                mask_o
);

    logic [VEX_XLEN-1:0] alu_res;
    logic [VEX_XLEN-1:0] lane_val;

    assign alu_res = vex_alu(op_i, data_a_i, data_b_i);

    // Inactive lanes feed the neutral word so the fold is undisturbed
    assign lane_val = (is_rdc_i && !mask_i) ? vex_rdc_identity(op_i) : alu_res;

    //----------------------------------------------------------
    // EX2 registers
    //----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (valid_i) begin
            result_o <= lane_val;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask_o <= 1'b0;
        end else if (valid_i) begin
            mask_o <= mask_i;
        end
    end

    // No fold defined for subtraction
    a_rdc_no_sub: assert property (
        @(posedge clk) disable iff (!rst_n)
        (valid_i && is_rdc_i) |-> (op_i != VEX_SUB)
    ) else $error("reduction issued with VEX_SUB");

endmodule

`default_nettype wire

// ==== verilog/vex_delay_pipe.sv ====
//----------------------------------------------------------
// Fixed-depth delay line for any packed payload
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module vex_delay_pipe #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  T     d_i,
    output T     q_o
);

    T stage_q [DEPTH];

    // Reset to zero also drops any tag valid bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q_o = stage_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== verilog/vex_rdc_tree.sv ====
//----------------------------------------------------------
// Cross-lane reduction tree
// Two pipelined fold levels, then the multi-uop accumulator
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module vex_rdc_tree
    import vex_pkg::*;
#(
    parameter int VECTOR_LANES = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  valid_i,
    input  logic                                  is_rdc_i,
    input  vex_op_e                               op_i,
    input  logic                                  head_uop_i,
    input  logic                                  end_uop_i,
    input  logic [VECTOR_LANES-1:0][VEX_XLEN-1:0] operands_i,
    output logic [VEX_XLEN-1:0]                   acc_o,
    output logic                                  rdc_valid_o
);

    // Level 1 width; two lanes pass straight through
    localparam int L1_N = (VECTOR_LANES > 2) ? VECTOR_LANES / 2 : 2;

    logic [VEX_XLEN-1:0] lvl1_d [L1_N];
    logic [VEX_XLEN-1:0] lvl1_q [L1_N];
    logic [VEX_XLEN-1:0] lvl2_d [2];
    logic [VEX_XLEN-1:0] lvl2_q [2];
    logic [VEX_XLEN-1:0] fold;
    logic [VEX_XLEN-1:0] acc_q;
    vex_op_e             op_l1;
    vex_op_e             op_l2;
    logic                vld_l1;
    logic                vld_l2;
    logic                head_l1;
    logic                head_l2;
    logic                end_l1;
    logic                end_l2;
    logic                rdc_open;

    generate
        if (VECTOR_LANES > 2) begin : g_lvl1_fold
            for (genvar i = 0; i < L1_N; i++) begin : g_pair
                assign lvl1_d[i] = vex_alu(op_i, operands_i[2*i], operands_i[2*i+1]);
            end
        end else begin : g_lvl1_pass
            for (genvar i = 0; i < 2; i++) begin : g_pass
                assign lvl1_d[i] = operands_i[i];
            end
        end
        if (L1_N > 2) begin : g_lvl2_fold
            for (genvar i = 0; i < 2; i++) begin : g_pair
                assign lvl2_d[i] = vex_alu(op_l1, lvl1_q[2*i], lvl1_q[2*i+1]);
            end
        end else begin : g_lvl2_pass
            for (genvar i = 0; i < 2; i++) begin : g_pass
                assign lvl2_d[i] = lvl1_q[i];
            end
        end
    endgenerate

    //----------------------------------------------------------
    // Stage control, EX3 and EX4
    //----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_l1   <= 1'b0;
            vld_l2   <= 1'b0;
            op_l1    <= VEX_ADD;
            op_l2    <= VEX_ADD;
            head_l1  <= 1'b0;
            head_l2  <= 1'b0;
            end_l1   <= 1'b0;
            end_l2   <= 1'b0;
            rdc_open <= 1'b0;
        end else begin
            vld_l1  <= valid_i && is_rdc_i;
            op_l1   <= op_i;
            head_l1 <= head_uop_i;
            end_l1  <= end_uop_i;
            vld_l2  <= vld_l1;
            op_l2   <= op_l1;
            head_l2 <= head_l1;
            end_l2  <= end_l1;
            // Open between a head and its end micro-op
            if (vld_l2) begin
                rdc_open <= !end_l2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && is_rdc_i) begin
            lvl1_q <= lvl1_d;
        end
        if (vld_l1) begin
            lvl2_q <= lvl2_d;
        end
        if (vld_l2) begin
            acc_q <= acc_o;
        end
    end

    // Last fold, then load or merge into the accumulator
    assign fold        = vex_alu(op_l2, lvl2_q[0], lvl2_q[1]);
    assign acc_o       = head_l2 ? fold : vex_alu(op_l2, acc_q, fold);
    assign rdc_valid_o = vld_l2 && end_l2;

    a_lanes_legal: assert property (
        @(posedge clk) VECTOR_LANES inside {2, 4, 8}
    ) else $error("VECTOR_LANES must be 2, 4 or 8");

    a_head_first: assert property (
        @(posedge clk) disable iff (!rst_n)
        (vld_l2 && !head_l2) |-> rdc_open
    ) else $error("reduction continued without a head micro-op");

endmodule

`default_nettype wire

// ==== verilog/vex_writeback.sv ====
//----------------------------------------------------------
// Writeback stage
// Registered lane enables, address, data and reduction done
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module vex_writeback
    import vex_pkg::*;
#(
    parameter int VECTOR_LANES = 8
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  vex_tag_t                                 tag_i,
    input  logic [VECTOR_LANES*(VEX_XLEN+1)-1:0]     elem_i,
    input  logic                                     rdc_valid_i,
    input  logic [VEX_XLEN-1:0]                      acc_i,
    output logic [VECTOR_LANES-1:0]                  wr_en_o,
    output logic [VEX_RADDR_W-1:0]                   wr_addr_o,
    output logic [VECTOR_LANES*VEX_XLEN-1:0]         wr_data_o,
    output logic                                     rdc_done_o
);

    localparam int DATA_W = VECTOR_LANES * VEX_XLEN;

    logic [DATA_W-1:0]       elem_data;
    logic [VECTOR_LANES-1:0] elem_mask;
    logic                    elem_wr;
    logic [VECTOR_LANES-1:0] wr_en_d;
    logic [DATA_W-1:0]       wr_data_d;

    // Results sit above the mask bits
    assign elem_data = elem_i[VECTOR_LANES +: DATA_W];
    assign elem_mask = elem_i[VECTOR_LANES-1:0];
    assign elem_wr   = tag_i.valid && !tag_i.is_rdc;

    always_comb begin
        wr_en_d   = '0;
        wr_data_d = elem_data;
        if (rdc_valid_i) begin
            // Folded value goes to lane 0 only
            wr_en_d[0]              = 1'b1;
            wr_data_d               = '0;
            wr_data_d[VEX_XLEN-1:0] = acc_i;
        end else if (elem_wr) begin
            wr_en_d = elem_mask;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en_o    <= '0;
            rdc_done_o <= 1'b0;
        end else begin
            wr_en_o    <= wr_en_d;
            rdc_done_o <= rdc_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rdc_valid_i || elem_wr) begin
            wr_addr_o <= tag_i.dst;
            wr_data_o <= wr_data_d;
        end
    end

    // Tree output and tag pipe must line up on the same micro-op
    a_rdc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        rdc_valid_i |-> (tag_i.valid && tag_i.is_rdc && tag_i.end_uop)
    ) else $error("reduction result out of step with writeback tag");

endmodule

`default_nettype wire

// ==== verilog/vex_top.sv ====
//----------------------------------------------------------
// Vector execution stage top level
// Lanes, tag and element delays, reduction tree, writeback
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module vex_top
    import vex_pkg::*;
#(
    parameter int VECTOR_LANES = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  valid_i,
    input  vex_op_e                               op_i,
    input  logic                                  is_rdc_i,
    input  logic                                  head_uop_i,
    input  logic                                  end_uop_i,
    input  logic [VEX_RADDR_W-1:0]                dst_i,
    input  logic [VECTOR_LANES-1:0]               mask_i,
    input  logic [VECTOR_LANES-1:0][VEX_XLEN-1:0] data_a_i,
    input  logic [VECTOR_LANES-1:0][VEX_XLEN-1:0] data_b_i,
    output logic [VECTOR_LANES-1:0]               wr_en_o,
    output logic [VEX_RADDR_W-1:0]                wr_addr_o,
    output logic [VECTOR_LANES*VEX_XLEN-1:0]      wr_data_o,
    output logic                                  rdc_done_o,
    output logic                                  vex_idle_o
);

    typedef struct packed {
        logic [VECTOR_LANES-1:0][VEX_XLEN-1:0] result;
        logic [VECTOR_LANES-1:0]               mask;
    } vex_elem_t;

    vex_tag_t                              tag_issue;
    vex_tag_t                              tag_ex2;
    vex_tag_t                              tag_wb;
    logic [VECTOR_LANES-1:0][VEX_XLEN-1:0] lane_res;
    logic [VECTOR_LANES-1:0]               lane_mask;
    vex_elem_t                             elem_ex2;
    vex_elem_t                             elem_wb;
    logic [VEX_XLEN-1:0]                   rdc_acc;
    logic                                  rdc_valid;

    assign tag_issue = '{valid: valid_i, dst: dst_i, op: op_i, is_rdc: is_rdc_i,
                         head_uop: head_uop_i, end_uop: end_uop_i};
    assign elem_ex2  = '{result: lane_res, mask: lane_mask};

    for (genvar k = 0; k < VECTOR_LANES; k++) begin : g_lane
        vex_lane u_lane (
            .clk      (clk),           .rst_n    (rst_n),
            .valid_i  (valid_i),       .op_i     (op_i),
            .is_rdc_i (is_rdc_i),      .mask_i   (mask_i[k]),
            .data_a_i (data_a_i[k]),   .data_b_i (data_b_i[k]),
            .result_o (lane_res[k]),   .mask_o   (lane_mask[k])
        );
    end

    //----------------------------------------------------------
    // Tag and element delays, aligned to EX2 and EX4
    //----------------------------------------------------------
    vex_delay_pipe #(.T(vex_tag_t), .DEPTH(1)) tag_ex2_pipe (
        .clk (clk), .rst_n (rst_n), .d_i (tag_issue), .q_o (tag_ex2)
    );
    vex_delay_pipe #(.T(vex_tag_t), .DEPTH(3)) tag_wb_pipe (
        .clk (clk), .rst_n (rst_n), .d_i (tag_issue), .q_o (tag_wb)
    );
    vex_delay_pipe #(.T(vex_elem_t), .DEPTH(2)) elem_pipe (
        .clk (clk), .rst_n (rst_n), .d_i (elem_ex2), .q_o (elem_wb)
    );

    vex_rdc_tree #(.VECTOR_LANES(VECTOR_LANES)) u_rdc_tree (
        .clk        (clk),              .rst_n      (rst_n),
        .valid_i    (tag_ex2.valid),    .is_rdc_i   (tag_ex2.is_rdc),
        .op_i       (tag_ex2.op),       .head_uop_i (tag_ex2.head_uop),
        .end_uop_i  (tag_ex2.end_uop),  .operands_i (lane_res),
        .acc_o      (rdc_acc),          .rdc_valid_o (rdc_valid)
    );

    vex_writeback #(.VECTOR_LANES(VECTOR_LANES)) u_writeback (
        .clk         (clk),        .rst_n      (rst_n),
        .tag_i       (tag_wb),     .elem_i     (elem_wb),
        .rdc_valid_i (rdc_valid),  .acc_i      (rdc_acc),
        .wr_en_o     (wr_en_o),    .wr_addr_o  (wr_addr_o),
        .wr_data_o   (wr_data_o),  .rdc_done_o (rdc_done_o)
    );

    assign vex_idle_o = ~(valid_i | tag_ex2.valid | tag_wb.valid);

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
//----------------------------------------------------------
// Testbench clock and reset source
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        // Release away from the active edge
        @(negedge clk_o);
        rst_n_o <= 1'b1;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== sim/tb_vex.sv ====
//----------------------------------------------------------
// Vector execution stage testbench
// Random micro-ops, reference model and per-cycle scoreboard
//----------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_vex
    import vex_pkg::*;
;

    localparam int LANES      = 8;
    localparam int LATENCY    = 4;
    localparam int CLK_PERIOD = 20;
    localparam int NUM_UOPS   = 47;

    typedef struct packed {
        logic [31:0]             due;
        logic [VEX_RADDR_W-1:0]  addr;
        logic [LANES-1:0]        en;
        logic [LANES*VEX_XLEN-1:0] data;
        logic                    done;
        logic [VEX_XLEN-1:0]     acc;
    } exp_t;

    logic                               clk;
    logic                               rst_n;
    logic                               valid_i;
    vex_op_e                            op_i;
    logic                               is_rdc_i;
    logic                               head_uop_i;
    logic                               end_uop_i;
    logic [VEX_RADDR_W-1:0]             dst_i;
    logic [LANES-1:0]                   mask_i;
    logic [LANES-1:0][VEX_XLEN-1:0]     data_a_i;
    logic [LANES-1:0][VEX_XLEN-1:0]     data_b_i;
    logic [LANES-1:0]                   wr_en_o;
    logic [VEX_RADDR_W-1:0]             wr_addr_o;
    logic [LANES*VEX_XLEN-1:0]          wr_data_o;
    logic                               rdc_done_o;
    logic                               vex_idle_o;

    logic [31:0]         seed = 32'h727323e4;
    logic [VEX_XLEN-1:0] ref_acc = '0;
    exp_t                exp_q[$];
    exp_t                cur;
    int                  cyc = 0;
    int                  n_checks = 0;
    int                  n_cmp_errors = 0;
    int                  n_seq_errors = 0;
    int                  idle_cnt;
    vex_op_e             rdc_ops[6] = '{VEX_ADD, VEX_AND, VEX_OR, VEX_XOR, VEX_MINU, VEX_MAXU};

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(16)) u_clk (
        .clk_o (clk), .rst_n_o (rst_n)
    );

    vex_top #(.VECTOR_LANES(LANES)) UUT (
        .clk        (clk),        .rst_n      (rst_n),
        .valid_i    (valid_i),    .op_i       (op_i),
        .is_rdc_i   (is_rdc_i),   .head_uop_i (head_uop_i),
        .end_uop_i  (end_uop_i),  .dst_i      (dst_i),
        .mask_i     (mask_i),     .data_a_i   (data_a_i),
        .data_b_i   (data_b_i),   .wr_en_o    (wr_en_o),
        .wr_addr_o  (wr_addr_o),  .wr_data_o  (wr_data_o),
        .rdc_done_o (rdc_done_o), .vex_idle_o (vex_idle_o)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [VEX_XLEN-1:0] lane_op(input vex_op_e op,
                                                     input logic [VEX_XLEN-1:0] x,
                                                     input logic [VEX_XLEN-1:0] y);
        case (op)
            VEX_ADD:  return x + y;
            VEX_SUB:  return x - y;
            VEX_AND:  return x & y;
            VEX_OR:   return x | y;
            VEX_XOR:  return x ^ y;
            VEX_MINU: return (x <= y) ? x : y;
            VEX_MAXU: return (x >= y) ? x : y;
            default:  return '0;
        endcase
    endfunction

    function automatic logic [VEX_XLEN-1:0] neutral_word(input vex_op_e op);
        case (op)
            VEX_AND, VEX_MINU: return {VEX_XLEN{1'b1}};
            default:           return '0;
        endcase
    endfunction

    // Expected write of one micro-op, plus the running accumulator
    function automatic exp_t ref_model(input vex_op_e op, input logic is_rdc,
                                       input logic head, input logic last,
                                       input logic [VEX_RADDR_W-1:0] dst,
                                       input logic [LANES-1:0] mask,
                                       input logic [LANES-1:0][VEX_XLEN-1:0] a,
                                       input logic [LANES-1:0][VEX_XLEN-1:0] b,
                                       input logic [VEX_XLEN-1:0] acc_in);
        exp_t                e;
        logic [VEX_XLEN-1:0] f;
        e      = '0;
        e.addr = dst;
        e.acc  = acc_in;
        if (!is_rdc) begin
            e.en = mask;
            for (int l = 0; l < LANES; l++) begin
                e.data[l*VEX_XLEN +: VEX_XLEN] = lane_op(op, a[l], b[l]);
            end
        end else begin
            f = head ? neutral_word(op) : acc_in;
            for (int l = 0; l < LANES; l++) begin
                if (mask[l]) begin
                    f = lane_op(op, f, lane_op(op, a[l], b[l]));
                end
            end
            e.acc = f;
            if (last) begin
                e.en            = {{(LANES-1){1'b0}}, 1'b1};
                e.data[VEX_XLEN-1:0] = f;
                e.done          = 1'b1;
            end
        end
        return e;
    endfunction

    task automatic issue_uop(input vex_op_e op, input logic is_rdc,
                             input logic head, input logic last);
        logic [LANES-1:0][VEX_XLEN-1:0] a;
        logic [LANES-1:0][VEX_XLEN-1:0] b;
        logic [LANES-1:0]               mask;
        logic [VEX_RADDR_W-1:0]         dst;
        exp_t                           e;
        for (int l = 0; l < LANES; l++) begin
            seed = lcg_next(seed);
            a[l] = seed;
            seed = lcg_next(seed);
            b[l] = seed;
        end
        seed = lcg_next(seed);
        mask = seed[23:16];
        dst  = seed[28:24];
        @(posedge clk);
        valid_i    <= 1'b1;
        op_i       <= op;
        is_rdc_i   <= is_rdc;
        head_uop_i <= head;
        end_uop_i  <= last;
        dst_i      <= dst;
        mask_i     <= mask;
        data_a_i   <= a;
        data_b_i   <= b;
        // cyc still holds the count before this edge
        e         = ref_model(op, is_rdc, head, last, dst, mask, a, b, ref_acc);
        e.due     = cyc + LATENCY + 1;
        ref_acc   = e.acc;
        exp_q.push_back(e);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        valid_i    <= 1'b0;
        is_rdc_i   <= 1'b0;
        head_uop_i <= 1'b0;
        end_uop_i  <= 1'b0;
    endtask

    task automatic show_mismatch(input string name, input logic [31:0] expv,
                                 input logic [31:0] actv);
        $display("Fail t=%0t %s expected %h got %h", $time, name, expv, actv);
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    //----------------------------------------------------------
    // Scoreboard, one compare per cycle
    //----------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n) begin
            cur = '0;
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                cur = exp_q.pop_front();
            end
            n_checks++;
            if (wr_en_o !== cur.en) begin
                show_mismatch("wr_en_o", 32'(cur.en), 32'(wr_en_o));
                n_cmp_errors++;
            end
            if (rdc_done_o !== cur.done) begin
                show_mismatch("rdc_done_o", 32'(cur.done), 32'(rdc_done_o));
                n_cmp_errors++;
            end
            if (cur.en != '0 && wr_addr_o !== cur.addr) begin
                show_mismatch("wr_addr_o", 32'(cur.addr), 32'(wr_addr_o));
                n_cmp_errors++;
            end
            for (int l = 0; l < LANES; l++) begin
                if (cur.en[l] && wr_data_o[l*VEX_XLEN +: VEX_XLEN] !==
                        cur.data[l*VEX_XLEN +: VEX_XLEN]) begin
                    show_mismatch($sformatf("wr_data_o lane %0d", l),
                                  cur.data[l*VEX_XLEN +: VEX_XLEN],
                                  wr_data_o[l*VEX_XLEN +: VEX_XLEN]);
                    n_cmp_errors++;
                end
            end
        end
    end

    initial begin
        #((NUM_UOPS + 100) * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        valid_i    = 1'b0;
        op_i       = VEX_ADD;
        is_rdc_i   = 1'b0;
        head_uop_i = 1'b0;
        end_uop_i  = 1'b0;
        dst_i      = '0;
        mask_i     = '0;
        data_a_i   = '0;
        data_b_i   = '0;
        @(posedge rst_n);
        if (wr_en_o !== '0 || rdc_done_o !== 1'b0 || vex_idle_o !== 1'b1) begin
            $display("Outputs not in their reset state after reset release");
            n_seq_errors++;
        end
        // Element-wise, every op back to back
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 7; k++) begin
                issue_uop(vex_op_e'(k), 1'b0, 1'b0, 1'b0);
            end
        end
        // Single micro-op reductions
        for (int k = 0; k < 6; k++) begin
            issue_uop(rdc_ops[k], 1'b1, 1'b1, 1'b1);
        end
        // Three-part reductions with element ops in between
        for (int r = 0; r < 2; r++) begin
            issue_uop(rdc_ops[r*5], 1'b1, 1'b1, 1'b0);
            issue_uop(VEX_XOR, 1'b0, 1'b0, 1'b0);
            issue_uop(rdc_ops[r*5], 1'b1, 1'b0, 1'b0);
            issue_uop(VEX_SUB, 1'b0, 1'b0, 1'b0);
            issue_uop(rdc_ops[r*5], 1'b1, 1'b0, 1'b1);
        end
        issue_uop(VEX_XOR, 1'b1, 1'b1, 1'b0);
        issue_uop(VEX_XOR, 1'b1, 1'b0, 1'b0);
        issue_uop(VEX_XOR, 1'b1, 1'b0, 1'b1);
        drive_idle();
        idle_cnt = 0;
        while (idle_cnt < 20) begin
            @(negedge clk);
            idle_cnt++;
            if (vex_idle_o) begin
                break;
            end
        end
        if (idle_cnt != LATENCY) begin
            $display("vex_idle_o rose %0d cycles after the last issue, not %0d",
                     idle_cnt, LATENCY);
            n_seq_errors++;
        end
        @(negedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected writes were never observed", exp_q.size());
            n_seq_errors++;
        end
        $display("checks=%0d scoreboard_errors=%0d sequence_errors=%0d",
                 n_checks, n_cmp_errors, n_seq_errors);
        if (n_cmp_errors == 0 && n_seq_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/vex_pkg.sv
verilog/vex_lane.sv
verilog/vex_delay_pipe.sv
verilog/vex_rdc_tree.sv
verilog/vex_writeback.sv
verilog/vex_top.sv
sim/tb_clock_gen.sv
sim/tb_vex.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vector execution testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_vex \
    -Mdir obj_dir -o vtb_vex

./obj_dir/vtb_vex > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
